// File: logic/bmc_pkg.sv
package bmc_pkg;

    // --------------------
    // bus widths
    // --------------------
    localparam int addr_width   = 32;
    localparam int data_width   = 32;

    // slave ports behind this master port
    localparam int num_slv      = 4;
    localparam int slv_id_width = 2;

    // --------------------
    // AHB field types
    // --------------------
    typedef logic [1:0] htrans_t;
    typedef logic [1:0] hresp_t;
    typedef logic [2:0] hburst_t;
    typedef logic [2:0] hsize_t;
    typedef logic [3:0] hprot_t;

    localparam htrans_t htrans_idle   = 2'b00;
    localparam htrans_t htrans_nonseq = 2'b10;

    localparam hresp_t hresp_ok    = 2'b00;
    localparam hresp_t hresp_error = 2'b01;

    // --------------------
    // port state machine
    // --------------------
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        // waiting for grant
        st_arb       = 3'd1,
        st_trans     = 3'd2,
        // first and last cycle of the two-cycle error response
        st_err_first = 3'd3,
        st_err_last  = 3'd4,
        // resp_mode may still be changing, defer one cycle
        st_mode_wait = 3'd5
    } ctrl_state_t;

endpackage

// File: logic/addr_phase_hold.sv
`timescale 1ns/1ns

module addr_phase_hold import bmc_pkg::*; (
    input  logic                  hclk,
    input  logic                  hresetn,
    input  htrans_t               hm_htrans,
    input  logic [addr_width-1:0] hm_haddr,
    input  hburst_t               hm_hburst,
    input  hprot_t                hm_hprot,
    input  hsize_t                hm_hsize,
    input  logic                  hm_hwrite,
    input  logic                  hm_hready,
    input  logic                  use_live,
    output htrans_t               mst_htrans,
    output logic [addr_width-1:0] mst_haddr,
    output hburst_t               mst_hburst,
    output hprot_t                mst_hprot,
    output hsize_t                mst_hsize,
    output logic                  mst_hwrite
);

    logic                  accept;
    htrans_t               hold_htrans;
    logic [addr_width-1:0] hold_haddr;
    hburst_t               hold_hburst;
    hprot_t                hold_hprot;
    hsize_t                hold_hsize;
    logic                  hold_hwrite;

    assign accept = hm_hready && (hm_htrans == htrans_nonseq);

    // copy of the last accepted address phase
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            hold_htrans <= htrans_idle;
            hold_haddr  <= '0;
            hold_hburst <= '0;
            hold_hprot  <= '0;
            hold_hsize  <= '0;
            hold_hwrite <= 1'b0;
        end else if (accept) begin
            hold_htrans <= hm_htrans;
            hold_haddr  <= hm_haddr;
            hold_hburst <= hm_hburst;
            hold_hprot  <= hm_hprot;
            hold_hsize  <= hm_hsize;
            hold_hwrite <= hm_hwrite;
        end
    end

    // live bus or replayed phase toward the slaves
    assign mst_htrans = use_live ? hm_htrans : hold_htrans;
    assign mst_haddr  = use_live ? hm_haddr  : hold_haddr;
    assign mst_hburst = use_live ? hm_hburst : hold_hburst;
    assign mst_hprot  = use_live ? hm_hprot  : hold_hprot;
    assign mst_hsize  = use_live ? hm_hsize  : hold_hsize;
    assign mst_hwrite = use_live ? hm_hwrite : hold_hwrite;

endmodule

// File: logic/slave_resp_route.sv
`timescale 1ns/1ns

module slave_resp_route import bmc_pkg::*; (
    input  logic                                hclk,
    input  logic                                hresetn,
    input  logic                                dec_en,
    input  logic [num_slv-1:0]                  slv_grant,
    input  logic [num_slv-1:0]                  slv_sel,
    input  logic [num_slv-1:0]                  hs_hready,
    input  logic [num_slv-1:0][data_width-1:0]  hs_hrdata,
    input  hresp_t [num_slv-1:0]                hs_hresp,
    output logic [data_width-1:0]               hm_hrdata,
    output logic                                route_hready,
    output hresp_t                              route_hresp,
    output logic                                route_granted
);

    logic [slv_id_width-1:0] next_slv_id;
    logic [slv_id_width-1:0] slv_id;
    // set when the decoded address had no granted slave
    logic                    unmapped;

    assign route_granted = |slv_grant;

    // --------------------
    // one-hot select to index
    // --------------------
    always_comb begin
        next_slv_id = '0;
        for (int i = 0; i < num_slv; i++) begin
            if (slv_sel[i]) begin
                next_slv_id = next_slv_id | slv_id_width'(i);
            end
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            slv_id   <= '0;
            unmapped <= 1'b1;
        end else if (dec_en) begin
            slv_id   <= next_slv_id;
            unmapped <= ~route_granted;
        end
    end

    // --------------------
    // data phase return path
    // --------------------
    always_comb begin
        if (unmapped) begin
            hm_hrdata    = '0;
            route_hready = 1'b0;
            route_hresp  = hresp_ok;
        end else begin
            hm_hrdata    = hs_hrdata[slv_id];
            route_hready = hs_hready[slv_id];
            route_hresp  = hs_hresp[slv_id];
        end
    end

endmodule

// File: logic/mst_ctrl_fsm.sv
`timescale 1ns/1ns

module mst_ctrl_fsm import bmc_pkg::*; (
    input  logic    hclk,
    input  logic    hresetn,
    input  htrans_t hm_htrans,
    input  logic    route_hready,
    input  hresp_t  route_hresp,
    input  logic    route_granted,
    input  logic    slv_sel_err,
    input  logic    resp_mode,
    input  logic    ctrl_wen,
    output logic    hm_hready,
    output hresp_t  hm_hresp,
    output logic    dec_en,
    output logic    use_live
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t err_entry;
    logic        accept;

    assign accept = hm_hready && (hm_htrans == htrans_nonseq);
    assign dec_en = accept || (state == st_arb);

    // first error state, picked by the current response mode
    assign err_entry = resp_mode ? st_err_first : st_err_last;

    // --------------------
    // state register
    // --------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (route_granted) begin
                    next_state = st_trans;
                end else if (slv_sel_err) begin
                    // control register written this cycle, wait for resp_mode to settle
                    next_state = ctrl_wen ? st_mode_wait : err_entry;
                end else if (hm_htrans == htrans_nonseq) begin
                    next_state = st_arb;
                end
            end
            st_arb: begin
                if (route_granted) begin
                    next_state = st_trans;
                end
            end
            st_trans: begin
                // nothing moves until the routed slave is ready
                if (route_hready) begin
                    if (route_granted) begin
                        next_state = st_trans;
                    end else if (slv_sel_err) begin
                        next_state = ctrl_wen ? st_mode_wait : err_entry;
                    end else if (hm_htrans == htrans_nonseq) begin
                        next_state = st_arb;
                    end else if (hm_htrans == htrans_idle) begin
                        next_state = st_idle;
                    end
                end
            end
            st_err_first: begin
                next_state = st_err_last;
            end
            st_err_last: begin
                if (hm_htrans == htrans_idle) begin
                    next_state = st_idle;
                end else if (route_granted) begin
                    next_state = st_trans;
                end else if (slv_sel_err) begin
                    next_state = err_entry;
                end else if (hm_htrans == htrans_nonseq) begin
                    next_state = st_arb;
                end else begin
                    next_state = st_idle;
                end
            end
            st_mode_wait: begin
                next_state = err_entry;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // --------------------
    // master response
    // --------------------
    always_comb begin
        case (state)
            st_idle: begin
                hm_hready = 1'b1;
                hm_hresp  = hresp_ok;
            end
            st_trans: begin
                hm_hready = route_hready;
                hm_hresp  = route_hresp;
            end
            st_err_first: begin
                hm_hready = 1'b0;
                hm_hresp  = hresp_error;
            end
            st_err_last: begin
                hm_hready = 1'b1;
                hm_hresp  = resp_mode ? hresp_error : hresp_ok;
            end
            // st_arb, st_mode_wait and anything unexpected stall with OKAY
            default: begin
                hm_hready = 1'b0;
                hm_hresp  = hresp_ok;
            end
        endcase
    end

    // live master fields only where the address phase is not being held
    assign use_live = (state == st_idle) || (state == st_trans) || (state == st_err_last);

endmodule

// File: logic/bmc_mst_port.sv
`timescale 1ns/1ns

module bmc_mst_port import bmc_pkg::*; (
    input  logic                                hclk,
    input  logic                                hresetn,
    // master side
    input  htrans_t                             hm_htrans,
    input  logic [addr_width-1:0]               hm_haddr,
    input  hburst_t                             hm_hburst,
    input  hprot_t                              hm_hprot,
    input  hsize_t                              hm_hsize,
    input  logic                                hm_hwrite,
    output logic [data_width-1:0]               hm_hrdata,
    output logic                                hm_hready,
    output hresp_t                              hm_hresp,
    // control register
    input  logic                                ctrl_wen,
    input  logic                                resp_mode,
    // decoder and arbiter
    input  logic                                slv_sel_err,
    input  logic [num_slv-1:0]                  slv_grant,
    input  logic [num_slv-1:0]                  slv_sel,
    output logic                                dec_en,
    // slave-side address bus
    output logic [addr_width-1:0]               mst_haddr,
    output hburst_t                             mst_hburst,
    output hprot_t                              mst_hprot,
    output hsize_t                              mst_hsize,
    output logic                                mst_hwrite,
    output htrans_t                             mst_htrans,
    // slave responses
    input  logic [num_slv-1:0]                  hs_hready,
    input  logic [num_slv-1:0][data_width-1:0]  hs_hrdata,
    input  hresp_t [num_slv-1:0]                hs_hresp
);

    logic   use_live;
    logic   route_hready;
    hresp_t route_hresp;
    logic   route_granted;

    addr_phase_hold hold_i (
        .hclk       (hclk),
        .hresetn    (hresetn),
        .hm_htrans  (hm_htrans),
        .hm_haddr   (hm_haddr),
        .hm_hburst  (hm_hburst),
        .hm_hprot   (hm_hprot),
        .hm_hsize   (hm_hsize),
        .hm_hwrite  (hm_hwrite),
        .hm_hready  (hm_hready),
        .use_live   (use_live),
        .mst_htrans (mst_htrans),
        .mst_haddr  (mst_haddr),
        .mst_hburst (mst_hburst),
        .mst_hprot  (mst_hprot),
        .mst_hsize  (mst_hsize),
        .mst_hwrite (mst_hwrite)
    );

    slave_resp_route route_i (
        .hclk          (hclk),
        .hresetn       (hresetn),
        .dec_en        (dec_en),
        .slv_grant     (slv_grant),
        .slv_sel       (slv_sel),
        .hs_hready     (hs_hready),
        .hs_hrdata     (hs_hrdata),
        .hs_hresp      (hs_hresp),
        .hm_hrdata     (hm_hrdata),
        .route_hready  (route_hready),
        .route_hresp   (route_hresp),
        .route_granted (route_granted)
    );

    mst_ctrl_fsm fsm_i (
        .hclk          (hclk),
        .hresetn       (hresetn),
        .hm_htrans     (hm_htrans),
        .route_hready  (route_hready),
        .route_hresp   (route_hresp),
        .route_granted (route_granted),
        .slv_sel_err   (slv_sel_err),
        .resp_mode     (resp_mode),
        .ctrl_wen      (ctrl_wen),
        .hm_hready     (hm_hready),
        .hm_hresp      (hm_hresp),
        .dec_en        (dec_en),
        .use_live      (use_live)
    );

endmodule

// File: tests/bmc_mst_port_sva.sv
`timescale 1ns/1ns

module bmc_mst_port_sva import bmc_pkg::*; (
    input logic                  hclk,
    input logic                  hresetn,
    input logic                  hm_hready,
    input hresp_t                hm_hresp,
    input logic                  resp_mode,
    input logic                  use_live,
    input htrans_t               mst_htrans,
    input logic [addr_width-1:0] mst_haddr,
    input hburst_t               mst_hburst,
    input hprot_t                mst_hprot,
    input hsize_t                mst_hsize,
    input logic                  mst_hwrite
);

    // port starts out ready
    a_ready_after_reset: assert property (@(posedge hclk) $rose(hresetn) |-> hm_hready)
        else $error("hm_hready low in the first cycle after reset");

    // ERROR with ready must follow a stalled ERROR cycle
    a_error_two_cycles: assert property (@(posedge hclk) disable iff (!hresetn)
        (hm_hready && hm_hresp == hresp_error && resp_mode) |-> $past(hm_hresp) == hresp_error)
        else $error("single-cycle ERROR response");

    // replayed phase holds while the master is stalled
    a_held_stable: assert property (@(posedge hclk) disable iff (!hresetn)
        (!hm_hready && !use_live && $past(!hm_hready && !use_live))
        |-> ($stable(mst_htrans) && $stable(mst_haddr) && $stable(mst_hburst)
             && $stable(mst_hprot) && $stable(mst_hsize) && $stable(mst_hwrite)))
        else $error("slave-side address phase changed while stalled");

endmodule

// File: tests/tb_bmc_mst_port.sv
`timescale 1ns/1ns

module tb_bmc_mst_port import bmc_pkg::*; ();

    localparam int num_tests  = 40;
    localparam int wait_limit = 16;

    logic                               hclk;
    logic                               hresetn;
    htrans_t                            hm_htrans;
    logic [addr_width-1:0]              hm_haddr;
    hburst_t                            hm_hburst;
    hprot_t                             hm_hprot;
    hsize_t                             hm_hsize;
    logic                               hm_hwrite;
    logic [data_width-1:0]              hm_hrdata;
    logic                               hm_hready;
    hresp_t                             hm_hresp;
    logic                               ctrl_wen;
    logic                               resp_mode;
    logic                               slv_sel_err;
    logic [num_slv-1:0]                 slv_grant;
    logic [num_slv-1:0]                 slv_sel;
    logic                               dec_en;
    logic [addr_width-1:0]              mst_haddr;
    hburst_t                            mst_hburst;
    hprot_t                             mst_hprot;
    hsize_t                             mst_hsize;
    logic                               mst_hwrite;
    htrans_t                            mst_htrans;
    logic [num_slv-1:0]                 hs_hready;
    logic [num_slv-1:0][data_width-1:0] hs_hrdata;
    hresp_t [num_slv-1:0]               hs_hresp;

    integer seed;
    int     errors;
    logic   timed_out;

    bmc_mst_port dut_i (.*);

    bind bmc_mst_port bmc_mst_port_sva sva_i (
        .hclk       (hclk),
        .hresetn    (hresetn),
        .hm_hready  (hm_hready),
        .hm_hresp   (hm_hresp),
        .resp_mode  (resp_mode),
        .use_live   (use_live),
        .mst_htrans (mst_htrans),
        .mst_haddr  (mst_haddr),
        .mst_hburst (mst_hburst),
        .mst_hprot  (mst_hprot),
        .mst_hsize  (mst_hsize),
        .mst_hwrite (mst_hwrite)
    );

    initial begin
        hclk = 1'b0;
        forever begin
            #50 hclk = ~hclk;
        end
    end

    // --------------------
    // helpers
    // --------------------
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic advance_cycle();
        @(posedge hclk);
        #10;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // slave-side address bus against an expected phase
    task automatic check_addr_phase(input htrans_t trans, input logic [addr_width-1:0] addr,
                                    input hburst_t burst, input hprot_t prot,
                                    input hsize_t size, input logic write);
        check_val("mst_htrans", 32'(trans), 32'(mst_htrans));
        check_val("mst_haddr", addr, mst_haddr);
        check_val("mst_hburst", 32'(burst), 32'(mst_hburst));
        check_val("mst_hprot", 32'(prot), 32'(mst_hprot));
        check_val("mst_hsize", 32'(size), 32'(mst_hsize));
        check_val("mst_hwrite", 32'(write), 32'(mst_hwrite));
    endtask

    task automatic drive_master(input htrans_t trans);
        hm_htrans = trans;
        hm_haddr  = $random(seed);
        hm_hburst = hburst_t'($random(seed));
        hm_hprot  = hprot_t'($random(seed));
        hm_hsize  = hsize_t'($random(seed));
        hm_hwrite = 1'($random(seed));
    endtask

    // count hready-low cycles and check the response while stalled
    task automatic wait_ready(input logic drive_slave, input logic [slv_id_width-1:0] slot,
                              input int ready_after, input hresp_t first_resp,
                              input hresp_t later_resp, output int stalls);
        logic done;
        done   = 1'b0;
        stalls = 0;
        while (!done && !timed_out) begin
            @(negedge hclk);
            if (hm_hready) begin
                done = 1'b1;
            end else if (stalls >= wait_limit) begin
                $display("timeout: hm_hready stayed low for %0d cycles", stalls);
                timed_out = 1'b1;
            end else begin
                check_val("hm_hresp", 32'(stalls == 0 ? first_resp : later_resp),
                          32'(hm_hresp));
                stalls++;
                advance_cycle();
                if (drive_slave) begin
                    hs_hready[slot] = (stalls >= ready_after);
                end
            end
        end
    endtask

    // --------------------
    // scenarios
    // --------------------
    task automatic run_mapped();
        logic [slv_id_width-1:0] s;
        int                      delay;
        int                      w;
        int                      stalls;
        logic [data_width-1:0]   data;
        hresp_t                  resp;
        logic [addr_width-1:0]   acc_addr;
        hburst_t                 acc_burst;
        hprot_t                  acc_prot;
        hsize_t                  acc_size;
        logic                    acc_write;

        s     = slv_id_width'(rand_below(num_slv));
        delay = rand_below(4);
        w     = rand_below(4);
        data  = $random(seed);
        resp  = (rand_below(4) == 0) ? hresp_error : hresp_ok;
        // two-cycle slave error needs at least one wait
        if (resp == hresp_error && w == 0) begin
            w = 1;
        end
        drive_master(htrans_nonseq);
        acc_addr    = hm_haddr;
        acc_burst   = hm_hburst;
        acc_prot    = hm_hprot;
        acc_size    = hm_hsize;
        acc_write   = hm_hwrite;
        slv_sel_err = 1'b0;
        slv_sel     = '0;
        slv_sel[s]  = 1'b1;
        slv_grant   = (delay == 0) ? slv_sel : '0;
        @(negedge hclk);
        check_val("dec_en", 32'd1, 32'(dec_en));
        check_val("hm_hready", 32'd1, 32'(hm_hready));
        // live master phase passes straight through in idle
        check_addr_phase(htrans_nonseq, acc_addr, acc_burst, acc_prot, acc_size, acc_write);
        // phase replayed toward the slaves until the grant
        for (int i = 0; i < delay; i++) begin
            advance_cycle();
            drive_master(htrans_idle);
            slv_grant = (i == delay - 1) ? slv_sel : '0;
            @(negedge hclk);
            check_val("hm_hready", 32'd0, 32'(hm_hready));
            check_val("dec_en", 32'd1, 32'(dec_en));
            check_addr_phase(htrans_nonseq, acc_addr, acc_burst, acc_prot, acc_size,
                             acc_write);
        end
        advance_cycle();
        hm_htrans = htrans_idle;
        slv_grant = '0;
        hs_hready = num_slv'($random(seed));
        for (int i = 0; i < num_slv; i++) begin
            hs_hrdata[slv_id_width'(i)] = $random(seed);
            hs_hresp[slv_id_width'(i)]  = hresp_t'($random(seed));
        end
        hs_hready[s] = (w == 0);
        hs_hrdata[s] = data;
        hs_hresp[s]  = resp;
        wait_ready(1'b1, s, w, resp, resp, stalls);
        check_val("wait_cycles", 32'(w), 32'(stalls));
        check_val("hm_hrdata", data, hm_hrdata);
        check_val("hm_hresp", 32'(resp), 32'(hm_hresp));
    endtask

    task automatic run_unmapped();
        logic   mode;
        logic   wen;
        int     stalls;
        hresp_t last_resp;

        mode = 1'(rand_below(2));
        wen  = 1'(rand_below(2));
        drive_master(htrans_nonseq);
        slv_grant   = '0;
        slv_sel     = '0;
        slv_sel_err = 1'b1;
        resp_mode   = mode;
        ctrl_wen    = wen;
        @(negedge hclk);
        check_val("dec_en", 32'd1, 32'(dec_en));
        advance_cycle();
        hm_htrans   = htrans_idle;
        slv_sel_err = 1'b0;
        ctrl_wen    = 1'b0;
        // ERROR mode stalls once
        // a control write in the detect cycle adds one OKAY stall
        wait_ready(1'b0, '0, 0, wen ? hresp_ok : hresp_error, hresp_error, stalls);
        check_val("stall_cycles", 32'(wen) + 32'(mode), 32'(stalls));
        last_resp = mode ? hresp_error : hresp_ok;
        check_val("hm_hresp", 32'(last_resp), 32'(hm_hresp));
        advance_cycle();
        @(negedge hclk);
        check_val("hm_hready", 32'd1, 32'(hm_hready));
        check_val("hm_hresp", 32'(hresp_ok), 32'(hm_hresp));
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int    err_before;
        int    tests_run;
        string kind;

        seed        = 8812;
        errors      = 0;
        timed_out   = 1'b0;
        tests_run   = 0;
        hresetn     = 1'b0;
        ctrl_wen    = 1'b0;
        resp_mode   = 1'b0;
        slv_sel_err = 1'b0;
        slv_grant   = '0;
        slv_sel     = '0;
        hm_htrans   = htrans_idle;
        hm_haddr    = '0;
        hm_hburst   = '0;
        hm_hprot    = '0;
        hm_hsize    = '0;
        hm_hwrite   = 1'b0;
        hs_hready   = '1;
        hs_hrdata   = '0;
        hs_hresp    = '0;
        repeat (5) @(posedge hclk);
        #10;
        hresetn = 1'b1;
        @(negedge hclk);
        check_val("hm_hready", 32'd1, 32'(hm_hready));
        check_val("hm_hresp", 32'(hresp_ok), 32'(hm_hresp));
        check_val("hm_hrdata", 32'd0, hm_hrdata);
        check_val("dec_en", 32'd0, 32'(dec_en));
        $display("test 0 reset: %s", (errors == 0) ? "ok" : "failed");
        for (int t = 1; t <= num_tests && !timed_out; t++) begin
            err_before = errors;
            advance_cycle();
            if (rand_below(2) == 0) begin
                kind = "mapped";
                run_mapped();
            end else begin
                kind = "unmapped";
                run_unmapped();
            end
            tests_run++;
            $display("test %0d %s: %s", t, kind,
                     (errors == err_before && !timed_out) ? "ok" : "failed");
        end
        $display("tests run %0d, errors %0d, timeout %0d", tests_run, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
logic/bmc_pkg.sv
logic/addr_phase_hold.sv
logic/slave_resp_route.sv
logic/mst_ctrl_fsm.sv
logic/bmc_mst_port.sv
tests/bmc_mst_port_sva.sv
tests/tb_bmc_mst_port.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the master port testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_bmc_mst_port \
    --Mdir "$build_dir" \
    -f all.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/Vtb_bmc_mst_port" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation passed" "$log"; then
    exit 0
fi
exit 1
